//--- rtl/ptw_pkg.sv
/*
 * Shared widths, types and cause codes for the Sv39 page table walker.
 * Imported by wildcard in every RTL and testbench module that uses it.
 */
package ptw_pkg;

    // Address and tag widths
    localparam int PPN_W     = 44;
    localparam int PA_W      = 56;
    localparam int VA_W      = 39;
    localparam int VPN_W     = 27;
    localparam int VPN_SEG_W = 9;
    localparam int PSCID_W   = 20;
    localparam int CAUSE_W   = 12;

    // Fault causes reported on cause_o
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PF    = 12'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_PF   = 12'd15;
    localparam logic [CAUSE_W-1:0] CAUSE_PT_CORRUPT = 12'd274;

    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [PA_W-1:0]    paddr_t;
    typedef logic [VA_W-1:0]    iova_t;
    typedef logic [VPN_W-1:0]   vpn_t;
    typedef logic [PSCID_W-1:0] pscid_t;
    typedef logic [CAUSE_W-1:0] cause_t;

    // Sv39 PTE, MSB first
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // LVL1 is the root table, 1G granule
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_t;

    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } ptw_state_t;

    // Reduced read channel, request side
    typedef struct packed {
        logic   ar_valid;
        paddr_t ar_addr;
        logic   r_ready;
    } mem_rd_req_t;

    // Reduced read channel, response side
    typedef struct packed {
        logic ar_ready;
        logic r_valid;
        pte_t r_data;
        logic r_err;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic leaf;
        logic page_fault;
        logic corrupt;
    } pte_verdict_t;

    typedef struct packed {
        vpn_t   vpn;
        pscid_t pscid;
        logic   is_1g;
        logic   is_2m;
        pte_t   content;
    } iotlb_update_t;

endpackage

//--- rtl/ptw_walk_ctx.sv
/*
 * Walk context: captures the request on start and tracks the global bit.
 * Also assembles the IOTLB update payload from the current leaf PTE.
 */
`timescale 1ns/1ps

module ptw_walk_ctx
    import ptw_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          start_i,
    input  logic          pte_taken_i,
    input  iova_t         iova_i,
    input  pscid_t        pscid_i,
    input  logic          is_store_i,
    input  ppn_t          satp_ppn_i,
    input  pte_t          pte_i,
    input  ptw_lvl_t      lvl_i,
    output iova_t         iova_o,
    output logic          is_store_o,
    output ppn_t          root_ppn_o,
    output iotlb_update_t iotlb_up_o
);

    iova_t  iova_q;
    pscid_t pscid_q;
    logic   is_store_q;
    ppn_t   root_ppn_q;
    logic   global_q;

    // Request fields, held for the whole walk
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            iova_q     <= iova_i;
            pscid_q    <= pscid_i;
            is_store_q <= is_store_i;
            root_ppn_q <= satp_ppn_i;
        end
    end

    // Sticky OR of the g bits seen on this walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (start_i) begin
            global_q <= 1'b0;
        end else if (pte_taken_i) begin
            global_q <= global_q | pte_i.g;
        end
    end

    assign iova_o     = iova_q;
    assign is_store_o = is_store_q;
    assign root_ppn_o = root_ppn_q;

    always_comb begin
        iotlb_up_o.vpn       = iova_q[VA_W-1 -: VPN_W];
        iotlb_up_o.pscid     = pscid_q;
        // Leaf level gives the page size
        iotlb_up_o.is_1g     = (lvl_i == LVL1);
        iotlb_up_o.is_2m     = (lvl_i == LVL2);
        iotlb_up_o.content   = pte_i;
        // Leaf g joins the bits from the upper levels
        iotlb_up_o.content.g = global_q | pte_i.g;
    end

endmodule

//--- rtl/ptw_pte_check.sv
/*
 * Combinational legality checks on the PTE returned by memory.
 * Gives leaf detection, page fault and response corruption to the walk FSM.
 */
`timescale 1ns/1ps

module ptw_pte_check
    import ptw_pkg::*;
(
    input  pte_t         pte_i,
    input  ptw_lvl_t     lvl_i,
    input  logic         is_store_i,
    input  logic         r_err_i,
    output pte_verdict_t verdict_o
);

    logic is_leaf;
    logic bad_encoding;
    logic bad_reserved;
    logic bad_align;
    logic bad_leaf_perm;
    logic bad_non_leaf;
    logic any_fault;

    // Readable or executable means this PTE ends the walk
    assign is_leaf = pte_i.r | pte_i.x;

    // Not valid, or the reserved w-without-r encoding
    assign bad_encoding = !pte_i.v || (pte_i.w && !pte_i.r);

    // Bits 63:54 must stay zero
    assign bad_reserved = |pte_i.reserved;

    // Superpage leaf needs the low PPN segments cleared
    always_comb begin
        bad_align = 1'b0;
        if (lvl_i == LVL1) begin
            bad_align = |pte_i.ppn[2*VPN_SEG_W-1:0];
        end else if (lvl_i == LVL2) begin
            bad_align = |pte_i.ppn[VPN_SEG_W-1:0];
        end
    end

    // A and R required, D also for stores
    assign bad_leaf_perm = !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    // d, a, u are reserved on pointers, and there is no level below LVL3
    assign bad_non_leaf = pte_i.a || pte_i.d || pte_i.u || (lvl_i == LVL3);

    always_comb begin
        any_fault = bad_encoding || bad_reserved;
        if (is_leaf) begin
            any_fault = any_fault || bad_align || bad_leaf_perm;
        end else begin
            any_fault = any_fault || bad_non_leaf;
        end
    end

    // A bus error wins over anything the data seems to say
    assign verdict_o.leaf       = is_leaf;
    assign verdict_o.corrupt    = r_err_i;
    assign verdict_o.page_fault = any_fault && !r_err_i;

endmodule

//--- rtl/ptw_walk_fsm.sv
/*
 * Walk FSM for the Sv39 walker: issues one PTE read per level.
 * Ends with an IOTLB update pulse or an error pulse carrying the cause.
 */
`timescale 1ns/1ps

module ptw_walk_fsm
    import ptw_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         init_ptw_i,
    input  mem_rd_rsp_t  mem_rsp_i,
    input  pte_verdict_t verdict_i,
    input  iova_t        iova_i,
    input  logic         is_store_i,
    input  ppn_t         root_ppn_i,
    input  ppn_t         satp_ppn_i,
    input  pte_t         pte_i,
    output mem_rd_req_t  mem_req_o,
    output ptw_lvl_t     lvl_o,
    output logic         start_o,
    output logic         pte_taken_o,
    output logic         ptw_active_o,
    output logic         update_o,
    output logic         ptw_error_o,
    output cause_t       cause_o
);

    ptw_state_t state_q, state_n;
    ptw_lvl_t   lvl_q, lvl_n;
    ppn_t       ptr_ppn_q, ptr_ppn_n;
    cause_t     cause_q, cause_n;
    ppn_t       base_ppn;
    logic [VPN_SEG_W-1:0] vpn_seg;
    logic       r_hsk;

    // Root table for the first read, last pointer PTE after that
    assign base_ppn = (lvl_q == LVL1) ? root_ppn_i : ptr_ppn_q;

    // VPN segment that indexes the table of the current level
    always_comb begin
        case (lvl_q)
            LVL1:    vpn_seg = iova_i[VA_W-1 -: VPN_SEG_W];
            LVL2:    vpn_seg = iova_i[VA_W-1-VPN_SEG_W -: VPN_SEG_W];
            default: vpn_seg = iova_i[VA_W-1-2*VPN_SEG_W -: VPN_SEG_W];
        endcase
    end

    assign r_hsk = (state_q == PROC_PTE) && mem_rsp_i.r_valid;

    // Read channel with the address held by the registers until ar_ready
    assign mem_req_o.ar_valid = (state_q == MEM_ACCESS);
    assign mem_req_o.ar_addr  = {base_ppn, vpn_seg, 3'b000};
    assign mem_req_o.r_ready  = r_hsk;

    assign start_o      = (state_q == IDLE) && init_ptw_i;
    assign pte_taken_o  = r_hsk;
    assign ptw_active_o = (state_q != IDLE);
    assign lvl_o        = lvl_q;

    // Legal leaf updates the IOTLB in the handshake cycle
    assign update_o = r_hsk && verdict_i.leaf && !verdict_i.page_fault && !verdict_i.corrupt;

    assign ptw_error_o = (state_q == ERROR);
    assign cause_o     = ptw_error_o ? cause_q : '0;

    always_comb begin
        state_n   = state_q;
        lvl_n     = lvl_q;
        ptr_ppn_n = ptr_ppn_q;
        cause_n   = cause_q;
        case (state_q)
            IDLE: begin
                if (init_ptw_i) begin
                    state_n = MEM_ACCESS;
                    lvl_n   = LVL1;
                end
            end
            MEM_ACCESS: begin
                if (mem_rsp_i.ar_ready) begin
                    state_n = PROC_PTE;
                end
            end
            PROC_PTE: begin
                if (r_hsk) begin
                    if (verdict_i.corrupt) begin
                        cause_n = CAUSE_PT_CORRUPT;
                        state_n = ERROR;
                    end else if (verdict_i.page_fault) begin
                        cause_n = is_store_i ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
                        state_n = ERROR;
                    end else if (verdict_i.leaf) begin
                        state_n = IDLE;
                    end else begin
                        // Pointer to the next table, one level down
                        state_n   = MEM_ACCESS;
                        ptr_ppn_n = pte_i.ppn;
                        lvl_n     = (lvl_q == LVL1) ? LVL2 : LVL3;
                    end
                end
            end
            default: begin
                // Error pulse lasts one cycle
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
        end
    end

    // Next table pointer and latched fault cause
    always_ff @(posedge clk_i) begin
        ptr_ppn_q <= ptr_ppn_n;
        cause_q   <= cause_n;
    end

endmodule

//--- rtl/ptw_sv39_top.sv
/*
 * Top level of the Sv39 page table walker for the IOMMU.
 * Connects the walk context, the PTE checker and the walk FSM.
 */
`timescale 1ns/1ps

module ptw_sv39_top
    import ptw_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          init_ptw_i,
    input  iova_t         iova_i,
    input  pscid_t        pscid_i,
    input  logic          is_store_i,
    input  ppn_t          satp_ppn_i,
    input  mem_rd_rsp_t   mem_rsp_i,
    output mem_rd_req_t   mem_req_o,
    output logic          ptw_active_o,
    output logic          update_o,
    output iotlb_update_t iotlb_up_o,
    output logic          ptw_error_o,
    output cause_t        cause_o
);

    logic         start;
    logic         pte_taken;
    ptw_lvl_t     lvl;
    pte_verdict_t verdict;
    iova_t        walk_iova;
    logic         walk_is_store;
    ppn_t         root_ppn;

    ptw_walk_ctx u_ctx (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .pte_taken_i (pte_taken),
        .iova_i      (iova_i),
        .pscid_i     (pscid_i),
        .is_store_i  (is_store_i),
        .satp_ppn_i  (satp_ppn_i),
        .pte_i       (mem_rsp_i.r_data),
        .lvl_i       (lvl),
        .iova_o      (walk_iova),
        .is_store_o  (walk_is_store),
        .root_ppn_o  (root_ppn),
        .iotlb_up_o  (iotlb_up_o)
    );

    // Checks the PTE as it arrives on the r channel
    ptw_pte_check u_check (
        .pte_i      (mem_rsp_i.r_data),
        .lvl_i      (lvl),
        .is_store_i (walk_is_store),
        .r_err_i    (mem_rsp_i.r_err),
        .verdict_o  (verdict)
    );

    ptw_walk_fsm u_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .init_ptw_i   (init_ptw_i),
        .mem_rsp_i    (mem_rsp_i),
        .verdict_i    (verdict),
        .iova_i       (walk_iova),
        .is_store_i   (walk_is_store),
        .root_ppn_i   (root_ppn),
        .satp_ppn_i   (satp_ppn_i),
        .pte_i        (mem_rsp_i.r_data),
        .mem_req_o    (mem_req_o),
        .lvl_o        (lvl),
        .start_o      (start),
        .pte_taken_o  (pte_taken),
        .ptw_active_o (ptw_active_o),
        .update_o     (update_o),
        .ptw_error_o  (ptw_error_o),
        .cause_o      (cause_o)
    );

endmodule

//--- tb/ptw_checker.sv
/*
 * Protocol assertions on the walker ports, bound into the top level.
 * Covers end pulse exclusivity, read handshake rules and reset values.
 */
`timescale 1ns/1ps

module ptw_checker
    import ptw_pkg::*;
(
    input logic        clk_i,
    input logic        rst_ni,
    input mem_rd_req_t mem_req_i,
    input mem_rd_rsp_t mem_rsp_i,
    input logic        ptw_active_i,
    input logic        update_i,
    input logic        ptw_error_i
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Walk ends one way only
    pulse_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_i && ptw_error_i))
        else begin
            fail_cnt++;
            $error("update and error pulse in the same cycle");
        end

    r_ready_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.r_ready |-> mem_rsp_i.r_valid)
        else begin
            fail_cnt++;
            $error("r_ready raised without r_valid");
        end

    // Request held with a stable address until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.ar_valid && !mem_rsp_i.ar_ready
        |=> mem_req_i.ar_valid && $stable(mem_req_i.ar_addr))
        else begin
            fail_cnt++;
            $error("ar_valid or ar_addr changed before ar_ready");
        end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !(ptw_active_i || mem_req_i.ar_valid || mem_req_i.r_ready
                      || update_i || ptw_error_i))
        else begin
            fail_cnt++;
            $error("control output high during reset");
        end

endmodule

bind ptw_sv39_top ptw_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .ptw_active_i (ptw_active_o),
    .update_i     (update_o),
    .ptw_error_i  (ptw_error_o)
);

//--- tb/ptw_scoreboard.sv
/*
 * Reference walk model for the Sv39 walker testbench.
 * Samples the DUT ports on the falling edge and checks addresses and outcomes.
 */
`timescale 1ns/1ps

module ptw_scoreboard
    import ptw_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          init_ptw_i,
    input  iova_t         iova_i,
    input  pscid_t        pscid_i,
    input  logic          is_store_i,
    input  ppn_t          satp_ppn_i,
    input  mem_rd_req_t   mem_req_i,
    input  mem_rd_rsp_t   mem_rsp_i,
    input  logic          ptw_active_i,
    input  logic          update_i,
    input  iotlb_update_t iotlb_up_i,
    input  logic          ptw_error_i,
    input  cause_t        cause_i,
    output int            err_cnt_o,
    output int            walk_cnt_o,
    output int            update_cnt_o,
    output int            fault_cnt_o
);

    typedef enum logic [1:0] {PH_IDLE, PH_ADDR, PH_DATA, PH_ERR} phase_t;
    typedef enum logic [1:0] {OUT_NEXT, OUT_LEAF, OUT_FAULT, OUT_CORRUPT} outcome_t;

    phase_t        phase = PH_IDLE;
    outcome_t      outcome;
    int            lvl;
    ppn_t          ptr_q;
    iova_t         iova_q;
    pscid_t        pscid_q;
    logic          store_q;
    logic          glob_q;
    paddr_t        exp_addr;
    iotlb_update_t exp_up;
    cause_t        exp_cause;
    int            err_cnt    = 0;
    int            walk_cnt   = 0;
    int            update_cnt = 0;
    int            fault_cnt  = 0;

    assign err_cnt_o    = err_cnt;
    assign walk_cnt_o   = walk_cnt;
    assign update_cnt_o = update_cnt;
    assign fault_cnt_o  = fault_cnt;

    // Table index at a level where level 0 uses iova bits 38:30
    function automatic logic [VPN_SEG_W-1:0] vpn_segment(input iova_t va, input int level);
        iova_t shifted;
        shifted = va >> (12 + VPN_SEG_W * (2 - level));
        return shifted[VPN_SEG_W-1:0];
    endfunction

    // Sv39 legality rules with a bus error taking precedence over the data
    function automatic outcome_t judge_pte(input pte_t p, input int level, input logic st,
                                           input logic err);
        logic leaf;
        logic misaligned;
        logic fault;
        leaf       = p.r || p.x;
        misaligned = (level == 0) ? (p.ppn[2*VPN_SEG_W-1:0] != '0)
                                  : ((level == 1) && (p.ppn[VPN_SEG_W-1:0] != '0));
        fault      = !p.v || (p.w && !p.r) || (p.reserved != '0);
        if (leaf) begin
            fault = fault || misaligned || !p.a || !p.r || (st && !p.d);
        end else begin
            fault = fault || p.a || p.d || p.u || (level == 2);
        end
        if (err) begin
            return OUT_CORRUPT;
        end
        if (fault) begin
            return OUT_FAULT;
        end
        return leaf ? OUT_LEAF : OUT_NEXT;
    endfunction

    task automatic report_mismatch(input string test, input logic [127:0] exp,
                                   input logic [127:0] act);
        err_cnt++;
        $display("** Error [%s] at %0t: expected %h, actual %h", test, $time, exp, act);
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("** Error at %0t: %s", $time, what);
    endtask

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            phase = PH_IDLE;
        end else begin
            if (phase != PH_IDLE && !ptw_active_i) begin
                report_failure("ptw_active_o low while a walk is running");
            end
            case (phase)
                PH_IDLE: begin
                    if (ptw_active_i || mem_req_i.ar_valid || update_i || ptw_error_i) begin
                        report_failure("DUT not idle between walks");
                    end
                    // Accepted on the next rising edge
                    if (init_ptw_i) begin
                        iova_q  = iova_i;
                        pscid_q = pscid_i;
                        store_q = is_store_i;
                        ptr_q   = satp_ppn_i;
                        glob_q  = 1'b0;
                        lvl     = 0;
                        phase   = PH_ADDR;
                        walk_cnt++;
                    end
                end
                PH_ADDR: begin
                    exp_addr = {ptr_q, vpn_segment(iova_q, lvl), 3'b000};
                    if (update_i || ptw_error_i) begin
                        report_failure("end pulse while a read request is pending");
                    end
                    if (!mem_req_i.ar_valid) begin
                        report_failure("read request missing or dropped before ar_ready");
                    end else if (mem_req_i.ar_addr != exp_addr) begin
                        report_mismatch("ar_addr", 128'(exp_addr), 128'(mem_req_i.ar_addr));
                    end
                    if (mem_req_i.ar_valid && mem_rsp_i.ar_ready) begin
                        phase = PH_DATA;
                    end
                end
                PH_DATA: begin
                    if (mem_req_i.ar_valid) begin
                        report_failure("second read request while a response is pending");
                    end
                    if (mem_req_i.r_ready != mem_rsp_i.r_valid) begin
                        report_failure("r_ready does not follow r_valid");
                    end
                    if (ptw_error_i) begin
                        report_failure("error pulse before the PTE arrived");
                    end
                    if (mem_rsp_i.r_valid) begin
                        outcome = judge_pte(mem_rsp_i.r_data, lvl, store_q, mem_rsp_i.r_err);
                        if (outcome == OUT_LEAF) begin
                            exp_up.vpn       = iova_q[VA_W-1:12];
                            exp_up.pscid     = pscid_q;
                            exp_up.is_1g     = (lvl == 0);
                            exp_up.is_2m     = (lvl == 1);
                            exp_up.content   = mem_rsp_i.r_data;
                            exp_up.content.g = glob_q | mem_rsp_i.r_data.g;
                            if (!update_i) begin
                                report_failure("no IOTLB update for a legal leaf");
                            end else if (iotlb_up_i != exp_up) begin
                                report_mismatch("iotlb_update", 128'(exp_up), 128'(iotlb_up_i));
                            end
                            update_cnt++;
                            phase = PH_IDLE;
                        end else begin
                            if (update_i) begin
                                report_failure("IOTLB update for a PTE that is no legal leaf");
                            end
                            if (outcome == OUT_NEXT) begin
                                // Descend one level
                                glob_q = glob_q | mem_rsp_i.r_data.g;
                                ptr_q  = mem_rsp_i.r_data.ppn;
                                lvl    = lvl + 1;
                                phase  = PH_ADDR;
                            end else begin
                                if (outcome == OUT_CORRUPT) begin
                                    exp_cause = CAUSE_PT_CORRUPT;
                                end else begin
                                    exp_cause = store_q ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
                                end
                                phase = PH_ERR;
                            end
                        end
                    end else if (update_i) begin
                        report_failure("IOTLB update without a PTE");
                    end
                end
                default: begin
                    if (update_i) begin
                        report_failure("IOTLB update on a faulting walk");
                    end
                    if (!ptw_error_i) begin
                        report_failure("no error pulse after an illegal PTE");
                    end else if (cause_i != exp_cause) begin
                        report_mismatch("cause", 128'(exp_cause), 128'(cause_i));
                    end
                    fault_cnt++;
                    phase = PH_IDLE;
                end
            endcase
        end
    end

endmodule

//--- tb/tb_ptw.sv
/*
 * Testbench top for the Sv39 walker: clock, reset, random walk requests and
 * a PTE memory responder with random ar_ready and r_valid delays.
 */
`timescale 1ns/1ps

module tb_ptw
    import ptw_pkg::*;
();

    localparam int NUM_WALKS  = 300;
    localparam int WAIT_LIMIT = 50;
    localparam int RUN_LIMIT  = 40000;

    logic          clk;
    logic          rst_n;
    logic          init_ptw;
    iova_t         iova;
    pscid_t        pscid;
    logic          is_store;
    ppn_t          satp_ppn;
    mem_rd_rsp_t   mem_rsp;
    mem_rd_req_t   mem_req;
    logic          ptw_active;
    logic          update;
    iotlb_update_t iotlb_up;
    logic          ptw_error;
    cause_t        cause;

    int   seed;
    int   tb_errs;
    int   sb_errs;
    int   chk_errs;
    int   walks;
    int   updates;
    int   faults;
    int   walk_idx;
    int   lvl;
    logic done;

    ptw_sv39_top dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .init_ptw_i   (init_ptw),
        .iova_i       (iova),
        .pscid_i      (pscid),
        .is_store_i   (is_store),
        .satp_ppn_i   (satp_ppn),
        .mem_rsp_i    (mem_rsp),
        .mem_req_o    (mem_req),
        .ptw_active_o (ptw_active),
        .update_o     (update),
        .iotlb_up_o   (iotlb_up),
        .ptw_error_o  (ptw_error),
        .cause_o      (cause)
    );

    ptw_scoreboard u_sb (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .init_ptw_i   (init_ptw),
        .iova_i       (iova),
        .pscid_i      (pscid),
        .is_store_i   (is_store),
        .satp_ppn_i   (satp_ppn),
        .mem_req_i    (mem_req),
        .mem_rsp_i    (mem_rsp),
        .ptw_active_i (ptw_active),
        .update_i     (update),
        .iotlb_up_i   (iotlb_up),
        .ptw_error_i  (ptw_error),
        .cause_i      (cause),
        .err_cnt_o    (sb_errs),
        .walk_cnt_o   (walks),
        .update_cnt_o (updates),
        .fault_cnt_o  (faults)
    );

    // Failures of the bound protocol assertions
    assign chk_errs = dut.u_checker.fail_cnt;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Last line of defence against a stuck run
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("** Error: run did not finish within %0d cycles", RUN_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    // Random PTE biased toward legal leaves and pointers for the given level
    task automatic make_pte(input int level, output pte_t p, output logic err);
        logic [63:0] raw;
        int          kind;
        raw   = {$random(seed), $random(seed)};
        kind  = $unsigned($random(seed)) % 16;
        p     = '0;
        err   = 1'b0;
        p.ppn = raw[PPN_W-1:0];
        p.g   = raw[50];
        if (kind == 0) begin
            // Bus error with random data
            p   = raw;
            err = 1'b1;
        end else if (kind == 1) begin
            p = raw;
        end else if (kind < 8) begin
            p.v = 1'b1;
            p.r = 1'b1;
            p.a = 1'b1;
            // Kind 6 leaves d clear, which faults on stores
            p.d = (kind != 6);
            p.w = raw[51];
            p.x = raw[52];
            p.u = raw[53];
            // kind 7 keeps a possibly misaligned superpage
            if (kind != 7 && level == 0) begin
                p.ppn[2*VPN_SEG_W-1:0] = '0;
            end else if (kind != 7 && level == 1) begin
                p.ppn[VPN_SEG_W-1:0] = '0;
            end
        end else if (kind < 15) begin
            // Pointer with u set on kind 14 only
            p.v = 1'b1;
            p.u = (kind == 14);
        end else begin
            p.v        = 1'b1;
            p.r        = 1'b1;
            p.a        = 1'b1;
            p.d        = 1'b1;
            p.reserved = raw[63:54] | 10'h1;
        end
    endtask

    // Issues one request, then a stray init while the walk is busy
    task automatic start_walk();
        logic [63:0] raw;
        logic [63:0] raw2;
        int          gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(posedge clk);
        raw  = {$random(seed), $random(seed)};
        raw2 = {$random(seed), $random(seed)};
        @(posedge clk);
        init_ptw <= 1'b1;
        iova     <= raw[VA_W-1:0];
        pscid    <= raw[63:44];
        is_store <= raw[40];
        satp_ppn <= raw2[PPN_W-1:0];
        @(posedge clk);
        init_ptw <= raw2[63];
        iova     <= raw2[VA_W-1:0];
        pscid    <= raw2[59:40];
        is_store <= ~raw[40];
        @(posedge clk);
        init_ptw <= 1'b0;
        @(negedge clk);
    endtask

    // Serves one PTE read and tells whether the walk has ended
    task automatic serve_read(input int level, output logic walk_done);
        int   wait_cnt;
        int   ar_delay;
        int   r_delay;
        pte_t pte;
        logic err;
        walk_done = 1'b0;
        wait_cnt  = 0;
        while (!mem_req.ar_valid && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!mem_req.ar_valid) begin
            $display("** Error: no read request within %0d cycles at %0t", WAIT_LIMIT, $time);
            tb_errs++;
            walk_done = 1'b1;
        end else begin
            ar_delay = $unsigned($random(seed)) % 4;
            r_delay  = $unsigned($random(seed)) % 4;
            make_pte(level, pte, err);
            repeat (ar_delay) @(posedge clk);
            @(posedge clk);
            mem_rsp.ar_ready <= 1'b1;
            @(posedge clk);
            mem_rsp.ar_ready <= 1'b0;
            repeat (r_delay) @(posedge clk);
            mem_rsp.r_valid <= 1'b1;
            mem_rsp.r_data  <= pte;
            mem_rsp.r_err   <= err;
            // Update comes in the handshake cycle, error one cycle later
            @(negedge clk);
            walk_done = update;
            @(posedge clk);
            mem_rsp.r_valid <= 1'b0;
            mem_rsp.r_err   <= 1'b0;
            @(negedge clk);
            walk_done = walk_done || ptw_error;
        end
    endtask

    initial begin
        seed     = 25306;
        tb_errs  = 0;
        rst_n    = 1'b1;
        init_ptw = 1'b0;
        iova     = '0;
        pscid    = '0;
        is_store = 1'b0;
        satp_ppn = '0;
        mem_rsp  = '0;
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (walk_idx = 0; walk_idx < NUM_WALKS; walk_idx++) begin
            start_walk();
            done = 1'b0;
            lvl  = 0;
            // Three levels at most
            while (!done && lvl < 3) begin
                serve_read(lvl, done);
                lvl++;
            end
            if (!done) begin
                $display("** Error: walk %0d did not end after three reads", walk_idx);
                tb_errs++;
            end
            if (tb_errs != 0) begin
                break;
            end
        end
        repeat (4) @(posedge clk);
        $display(
            "Walks %0d, updates %0d, faults %0d, errors: scoreboard %0d, tb %0d, checker %0d",
            walks, updates, faults, sb_errs, tb_errs, chk_errs);
        if (sb_errs == 0 && tb_errs == 0 && chk_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
rtl/ptw_pkg.sv
rtl/ptw_walk_ctx.sv
rtl/ptw_pte_check.sv
rtl/ptw_walk_fsm.sv
rtl/ptw_sv39_top.sv
tb/ptw_checker.sv
tb/ptw_scoreboard.sv
tb/tb_ptw.sv

//--- run.sh
#!/bin/sh
# Build the walker testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ptw -f flist.f \
    -o tb_ptw_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_ptw_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
